// ==== hdl/mipsPkg.sv ====
package mipsPkg;

	// Word and register index sizes
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount = 2 ** regAddrWidth;
	localparam int strbWidth = dataWidth / 8;

	// Immediate and jump target are the low bits of the instruction
	localparam int immWidth = 16;
	localparam int targetWidth = 26;

	// Fetch increment, one word
	localparam logic [dataWidth-1:0] pcStep = dataWidth'(strbWidth);

	// Primary opcode field
	typedef enum logic [5:0] {
		rType = 6'd0,
		jType = 6'd2,
		beq   = 6'd4,
		addi  = 6'd8,
		andi  = 6'd12,
		ori   = 6'd13,
		lw    = 6'd35,
		sw    = 6'd43
	} opcodeT;

	// R-type funct field
	typedef enum logic [5:0] {
		functAdd = 6'd32,
		functSub = 6'd34,
		functAnd = 6'd36,
		functOr  = 6'd37,
		functSlt = 6'd42
	} functT;

	// Controller states, wait states hold for the AXI handshake
	typedef enum logic [3:0] {
		fetch, fetchWait, decode, memAdr,
		memRead, memReadWait, memWriteback,
		memWrite, memWriteWait, execute, aluWriteback,
		branch, itypeExecute, itypeWriteback, jump
	} stateT;

	// ALU operation class from the controller
	typedef enum logic [1:0] {
		aluAdd   = 2'b00,
		aluSub   = 2'b01,
		aluFunct = 2'b10,
		aluItype = 2'b11
	} aluOpT;

	// ALU function select
	typedef enum logic [3:0] {
		ctrlAnd = 4'd0,
		ctrlOr  = 4'd1,
		ctrlAdd = 4'd2,
		ctrlSub = 4'd6,
		ctrlSlt = 4'd7
	} aluCtrlT;

	// Instruction word, imm and target overlap rd/shamt/funct
	typedef struct packed {
		opcodeT opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [regAddrWidth-1:0] shamt;
		functT funct;
	} instrT;

	// Controller to datapath
	typedef struct packed {
		// Mux selects
		logic memToReg;
		logic iOrD;
		logic regDst;
		logic [1:0] pcSrc;
		logic aluSrcA;
		logic [1:0] aluSrcB;
		logic extOp;
		// Register enables
		logic irWrite;
		logic mdrWrite;
		logic pcWrite;
		logic branch;
		logic regWrite;
		logic aluOutWrite;
		// AXI strobes
		logic arValid;
		logic awValid;
		logic wValid;
		logic bReady;
		logic rReady;
	} ctrlT;

	// Master side of AXI4-Lite
	typedef struct packed {
		logic [dataWidth-1:0] arAddr;
		logic arValid;
		logic rReady;
		logic [dataWidth-1:0] awAddr;
		logic awValid;
		logic [dataWidth-1:0] wData;
		logic [strbWidth-1:0] wStrb;
		logic wValid;
		logic bReady;
	} axiReqT;

	// Slave side of AXI4-Lite
	typedef struct packed {
		logic arReady;
		logic rValid;
		logic [dataWidth-1:0] rData;
		logic [1:0] rResp;
		logic awReady;
		logic wReady;
		logic bValid;
		logic [1:0] bResp;
	} axiRspT;

endpackage

// ==== hdl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input logic cclk,
	input logic rstb,
	input mipsPkg::instrT instr,
	input mipsPkg::axiRspT axiRsp,
	output mipsPkg::ctrlT ctrl,
	output mipsPkg::aluOpT aluOp
);

	mipsPkg::stateT state;
	mipsPkg::stateT nextState;

	// Valids are registered so they stay up until their own transfer
	logic arValidQ;
	logic awValidQ;
	logic wValidQ;

	// Handshake completions
	logic arDone;
	logic rDone;
	logic bDone;
	logic isLogicImm;

	assign arDone = arValidQ && axiRsp.arReady;
	// Read data accepted only in the two read wait states
	assign rDone = ((state == mipsPkg::fetchWait) || (state == mipsPkg::memReadWait))
		&& axiRsp.rValid;
	assign bDone = (state == mipsPkg::memWriteWait) && axiRsp.bValid;

	// andi and ori take a zero-extended immediate
	assign isLogicImm = (instr.opcode == mipsPkg::andi) || (instr.opcode == mipsPkg::ori);

	// Next state
	always_comb begin
		nextState = state;
		case (state)
			mipsPkg::fetch: begin
				if (arDone) begin
					nextState = mipsPkg::fetchWait;
				end
			end
			mipsPkg::fetchWait: begin
				if (rDone) begin
					nextState = mipsPkg::decode;
				end
			end
			mipsPkg::decode: begin
				case (instr.opcode)
					mipsPkg::lw, mipsPkg::sw: nextState = mipsPkg::memAdr;
					mipsPkg::rType: nextState = mipsPkg::execute;
					mipsPkg::beq: nextState = mipsPkg::branch;
					mipsPkg::addi, mipsPkg::andi, mipsPkg::ori: nextState = mipsPkg::itypeExecute;
					mipsPkg::jType: nextState = mipsPkg::jump;
					// Unknown opcode, back to fetch
					default: nextState = mipsPkg::fetch;
				endcase
			end
			mipsPkg::memAdr: begin
				nextState = (instr.opcode == mipsPkg::sw) ? mipsPkg::memWrite : mipsPkg::memRead;
			end
			mipsPkg::memRead: begin
				if (arDone) begin
					nextState = mipsPkg::memReadWait;
				end
			end
			mipsPkg::memReadWait: begin
				if (rDone) begin
					nextState = mipsPkg::memWriteback;
				end
			end
			// Both channels presented for one cycle, then tracked in the wait state
			mipsPkg::memWrite: nextState = mipsPkg::memWriteWait;
			mipsPkg::memWriteWait: begin
				if (bDone) begin
					nextState = mipsPkg::fetch;
				end
			end
			mipsPkg::execute: nextState = mipsPkg::aluWriteback;
			mipsPkg::itypeExecute: nextState = mipsPkg::itypeWriteback;
			default: nextState = mipsPkg::fetch;
		endcase
	end

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			state <= mipsPkg::fetch;
			arValidQ <= 1'b0;
			awValidQ <= 1'b0;
			wValidQ <= 1'b0;
		end else begin
			state <= nextState;
			// Read address valid for the whole fetch or memRead stay
			arValidQ <= (nextState == mipsPkg::fetch) || (nextState == mipsPkg::memRead);
			// Each write channel drops after its own transfer
			awValidQ <= (nextState == mipsPkg::memWrite) || (awValidQ && !axiRsp.awReady);
			wValidQ <= (nextState == mipsPkg::memWrite) || (wValidQ && !axiRsp.wReady);
		end
	end

	// Datapath controls from state and handshake
	always_comb begin
		ctrl = '0;
		aluOp = mipsPkg::aluAdd;
		ctrl.arValid = arValidQ;
		ctrl.awValid = awValidQ;
		ctrl.wValid = wValidQ;
		case (state)
			mipsPkg::fetchWait: begin
				// PC + 4 written back as the instruction lands
				ctrl.rReady = 1'b1;
				ctrl.aluSrcB = 2'b01;
				ctrl.irWrite = rDone;
				ctrl.pcWrite = rDone;
			end
			mipsPkg::decode: begin
				// Branch target into ALUOut
				ctrl.aluSrcB = 2'b11;
				ctrl.aluOutWrite = 1'b1;
			end
			mipsPkg::memAdr: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
				ctrl.aluOutWrite = 1'b1;
			end
			mipsPkg::memRead: ctrl.iOrD = 1'b1;
			mipsPkg::memReadWait: begin
				ctrl.iOrD = 1'b1;
				ctrl.rReady = 1'b1;
				ctrl.mdrWrite = rDone;
			end
			mipsPkg::memWriteback: begin
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::memWrite: ctrl.iOrD = 1'b1;
			mipsPkg::memWriteWait: begin
				// Address held while awValid may still be pending
				ctrl.iOrD = 1'b1;
				ctrl.bReady = 1'b1;
			end
			mipsPkg::execute: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluOutWrite = 1'b1;
				aluOp = mipsPkg::aluFunct;
			end
			mipsPkg::aluWriteback: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			mipsPkg::branch: begin
				// Compare A and B, take target on zero
				ctrl.aluSrcA = 1'b1;
				ctrl.pcSrc = 2'b01;
				ctrl.branch = 1'b1;
				aluOp = mipsPkg::aluSub;
			end
			mipsPkg::itypeExecute: begin
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'b10;
				ctrl.extOp = isLogicImm;
				ctrl.aluOutWrite = 1'b1;
				aluOp = mipsPkg::aluItype;
			end
			mipsPkg::itypeWriteback: ctrl.regWrite = 1'b1;
			mipsPkg::jump: begin
				ctrl.pcSrc = 2'b10;
				ctrl.pcWrite = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== hdl/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder (
	input mipsPkg::aluOpT aluOp,
	input mipsPkg::functT funct,
	input mipsPkg::opcodeT opcode,
	output mipsPkg::aluCtrlT aluCtrl
);

	always_comb begin
		case (aluOp)
			// Address and PC arithmetic
			mipsPkg::aluAdd: aluCtrl = mipsPkg::ctrlAdd;
			// beq compare
			mipsPkg::aluSub: aluCtrl = mipsPkg::ctrlSub;
			// R-type, from funct
			mipsPkg::aluFunct: begin
				case (funct)
					mipsPkg::functAdd: aluCtrl = mipsPkg::ctrlAdd;
					mipsPkg::functSub: aluCtrl = mipsPkg::ctrlSub;
					mipsPkg::functAnd: aluCtrl = mipsPkg::ctrlAnd;
					mipsPkg::functOr: aluCtrl = mipsPkg::ctrlOr;
					mipsPkg::functSlt: aluCtrl = mipsPkg::ctrlSlt;
					default: aluCtrl = mipsPkg::ctrlAdd;
				endcase
			end
			// I-type, from opcode
			default: begin
				case (opcode)
					mipsPkg::andi: aluCtrl = mipsPkg::ctrlAnd;
					mipsPkg::ori: aluCtrl = mipsPkg::ctrlOr;
					default: aluCtrl = mipsPkg::ctrlAdd;
				endcase
			end
		endcase
	end

endmodule

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic cclk,
	input logic rstb,
	input logic [mipsPkg::regAddrWidth-1:0] readAddrA,
	input logic [mipsPkg::regAddrWidth-1:0] readAddrB,
	input logic [mipsPkg::regAddrWidth-1:0] writeAddr,
	input logic [mipsPkg::dataWidth-1:0] writeData,
	input logic writeEn,
	output logic [mipsPkg::dataWidth-1:0] readDataA,
	output logic [mipsPkg::dataWidth-1:0] readDataB
);

	logic [mipsPkg::dataWidth-1:0] regs [mipsPkg::regCount];

	// Synchronous write, r0 never written
	always_ff @(posedge cclk) begin
		if (!rstb) begin
			for (int i = 0; i < mipsPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Asynchronous reads, r0 reads zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps

module datapath (
	input logic cclk,
	input logic rstb,
	input mipsPkg::ctrlT ctrl,
	input mipsPkg::aluCtrlT aluCtrl,
	input logic [mipsPkg::dataWidth-1:0] rData,
	output mipsPkg::instrT instr,
	output mipsPkg::axiReqT axiReq
);

	// Architectural and holding registers
	logic [mipsPkg::dataWidth-1:0] pc;
	logic [mipsPkg::dataWidth-1:0] mdr;
	logic [mipsPkg::dataWidth-1:0] regA;
	logic [mipsPkg::dataWidth-1:0] regB;
	logic [mipsPkg::dataWidth-1:0] aluOut;

	logic [mipsPkg::dataWidth-1:0] instrBits;
	logic [mipsPkg::immWidth-1:0] imm;
	logic [mipsPkg::dataWidth-1:0] extImm;
	logic [mipsPkg::dataWidth-1:0] jumpAddr;
	logic [mipsPkg::dataWidth-1:0] srcA;
	logic [mipsPkg::dataWidth-1:0] srcB;
	logic [mipsPkg::dataWidth-1:0] aluResult;
	logic zero;
	logic [mipsPkg::dataWidth-1:0] pcNext;
	logic pcEn;
	logic [mipsPkg::dataWidth-1:0] readDataA;
	logic [mipsPkg::dataWidth-1:0] readDataB;
	logic [mipsPkg::regAddrWidth-1:0] writeAddr;
	logic [mipsPkg::dataWidth-1:0] writeData;
	logic [mipsPkg::dataWidth-1:0] memAddr;

	assign instrBits = instr;
	assign imm = instrBits[mipsPkg::immWidth-1:0];

	// Zero extend for andi/ori, else sign extend
	assign extImm = ctrl.extOp
		? {{(mipsPkg::dataWidth-mipsPkg::immWidth){1'b0}}, imm}
		: {{(mipsPkg::dataWidth-mipsPkg::immWidth){imm[mipsPkg::immWidth-1]}}, imm};

	// Jump keeps the upper PC bits of the next instruction
	assign jumpAddr = {pc[mipsPkg::dataWidth-1:mipsPkg::targetWidth+2],
		instrBits[mipsPkg::targetWidth-1:0], 2'b00};

	registerFile registerFileI (
		.cclk(cclk),
		.rstb(rstb),
		.readAddrA(instr.rs),
		.readAddrB(instr.rt),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeEn(ctrl.regWrite),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	// Destination is rd for R-type, rt otherwise
	assign writeAddr = ctrl.regDst ? instr.rd : instr.rt;
	assign writeData = ctrl.memToReg ? mdr : aluOut;

	// ALU operands
	assign srcA = ctrl.aluSrcA ? regA : pc;
	always_comb begin
		case (ctrl.aluSrcB)
			2'b00: srcB = regB;
			2'b01: srcB = mipsPkg::pcStep;
			2'b10: srcB = extImm;
			default: srcB = {extImm[mipsPkg::dataWidth-3:0], 2'b00};
		endcase
	end

	always_comb begin
		case (aluCtrl)
			mipsPkg::ctrlAnd: aluResult = srcA & srcB;
			mipsPkg::ctrlOr: aluResult = srcA | srcB;
			mipsPkg::ctrlSub: aluResult = srcA - srcB;
			// Signed compare
			mipsPkg::ctrlSlt: aluResult = {{(mipsPkg::dataWidth-1){1'b0}},
				($signed(srcA) < $signed(srcB))};
			default: aluResult = srcA + srcB;
		endcase
	end
	assign zero = (aluResult == '0);

	// PC source: ALU result, ALUOut (branch target) or jump address
	always_comb begin
		case (ctrl.pcSrc)
			2'b01: pcNext = aluOut;
			2'b10: pcNext = jumpAddr;
			default: pcNext = aluResult;
		endcase
	end
	assign pcEn = ctrl.pcWrite || (ctrl.branch && zero);

	always_ff @(posedge cclk) begin
		if (!rstb) begin
			pc <= '0;
		end else if (pcEn) begin
			pc <= pcNext;
		end
	end

	// Instruction and data capture on read transfer
	always_ff @(posedge cclk) begin
		if (ctrl.irWrite) begin
			instr <= rData;
		end
		if (ctrl.mdrWrite) begin
			mdr <= rData;
		end
		if (ctrl.aluOutWrite) begin
			aluOut <= aluResult;
		end
		// Operands follow the register file every cycle
		regA <= readDataA;
		regB <= readDataB;
	end

	// AXI request, one address for read and write
	assign memAddr = ctrl.iOrD ? aluOut : pc;
	always_comb begin
		axiReq.arAddr = memAddr;
		axiReq.arValid = ctrl.arValid;
		axiReq.rReady = ctrl.rReady;
		axiReq.awAddr = memAddr;
		axiReq.awValid = ctrl.awValid;
		axiReq.wData = regB;
		// Word stores only
		axiReq.wStrb = '1;
		axiReq.wValid = ctrl.wValid;
		axiReq.bReady = ctrl.bReady;
	end

endmodule

// ==== hdl/multicycleCore.sv ====
`timescale 1ns/1ps

module multicycleCore (
	input logic cclk,
	input logic rstb,
	output mipsPkg::axiReqT axiReq,
	input mipsPkg::axiRspT axiRsp
);

	mipsPkg::instrT instr;
	mipsPkg::ctrlT ctrl;
	mipsPkg::aluOpT aluOp;
	mipsPkg::aluCtrlT aluCtrl;

	// State machine
	controlUnit controlUnitI (
		.cclk(cclk),
		.rstb(rstb),
		.instr(instr),
		.axiRsp(axiRsp),
		.ctrl(ctrl),
		.aluOp(aluOp)
	);

	// ALU function from op class and funct
	aluDecoder aluDecoderI (
		.aluOp(aluOp),
		.funct(instr.funct),
		.opcode(instr.opcode),
		.aluCtrl(aluCtrl)
	);

	datapath datapathI (
		.cclk(cclk),
		.rstb(rstb),
		.ctrl(ctrl),
		.aluCtrl(aluCtrl),
		.rData(axiRsp.rData),
		.instr(instr),
		.axiReq(axiReq)
	);

endmodule

// ==== dv/axiLiteMemoryModel.sv ====
`timescale 1ns/1ps

module axiLiteMemoryModel (
	input logic cclk,
	input logic rstb,
	input logic slowMode,
	input mipsPkg::axiReqT axiReq,
	output mipsPkg::axiRspT axiRsp
);

	localparam int memWords = 1024;
	localparam int maxDelay = 3;

	logic [31:0] mem [memWords];
	// Store log in arrival order
	logic [31:0] storeAddrQ [$];
	logic [31:0] storeDataQ [$];
	integer seed;

	// Transfers seen on the last rising edge
	logic arFire;
	logic rFire;
	logic awFire;
	logic wFire;
	logic bFire;
	logic [31:0] rdAddr;
	logic [31:0] wrAddr;
	logic [31:0] wrData;
	logic haveAw;
	logic haveW;
	logic rPending;
	logic bPending;
	// Countdowns, -1 means not started
	int arWait;
	int awWait;
	int wWait;
	int rWait;
	int bWait;

	initial begin
		seed = 32'h2774;
		axiRsp = '0;
		arWait = -1;
		awWait = -1;
		wWait = -1;
		rWait = 0;
		bWait = 0;
		haveAw = 1'b0;
		haveW = 1'b0;
		rPending = 1'b0;
		bPending = 1'b0;
	end

	// Fixed worst case in slow mode, else 0 to 3 cycles
	function automatic int pickDelay();
		int d;
		if (slowMode) begin
			d = maxDelay;
		end else begin
			d = int'($unsigned($random(seed)) % (maxDelay + 1));
		end
		return d;
	endfunction

	function automatic int memIndex(logic [31:0] addr);
		return int'((addr >> 2) % memWords);
	endfunction

	// Fill word depends on its own byte address
	task automatic clearMemory();
		for (int i = 0; i < memWords; i++) begin
			mem[i] = 32'(i * 4) ^ 32'hfc00_0000;
		end
	endtask

	task automatic writeWord(logic [31:0] addr, logic [31:0] data);
		mem[memIndex(addr)] = data;
	endtask

	task automatic clearLog();
		storeAddrQ.delete();
		storeDataQ.delete();
	endtask

	function automatic int storeCount();
		return storeAddrQ.size();
	endfunction

	function automatic logic [31:0] storeAddrAt(int i);
		return storeAddrQ[i];
	endfunction

	function automatic logic [31:0] storeDataAt(int i);
		return storeDataQ[i];
	endfunction

	// Sample handshakes and payloads on the rising edge
	always @(posedge cclk) begin
		arFire <= axiReq.arValid && axiRsp.arReady;
		rFire <= axiReq.rReady && axiRsp.rValid;
		awFire <= axiReq.awValid && axiRsp.awReady;
		wFire <= axiReq.wValid && axiRsp.wReady;
		bFire <= axiReq.bReady && axiRsp.bValid;
		if (axiReq.arValid && axiRsp.arReady) begin
			rdAddr <= axiReq.arAddr;
		end
		if (axiReq.awValid && axiRsp.awReady) begin
			wrAddr <= axiReq.awAddr;
		end
		if (axiReq.wValid && axiRsp.wReady) begin
			wrData <= axiReq.wData;
		end
	end

	// Responses change on the falling edge
	always @(negedge cclk) begin
		if (!rstb) begin
			axiRsp = '0;
			arWait = -1;
			awWait = -1;
			wWait = -1;
			haveAw = 1'b0;
			haveW = 1'b0;
			rPending = 1'b0;
			bPending = 1'b0;
		end else begin
			// Read address
			if (arFire) begin
				axiRsp.arReady = 1'b0;
				rPending = 1'b1;
				rWait = pickDelay();
			end else if (axiReq.arValid && !axiRsp.arReady) begin
				if (arWait < 0) begin
					arWait = pickDelay();
				end
				if (arWait == 0) begin
					axiRsp.arReady = 1'b1;
					arWait = -1;
				end else begin
					arWait--;
				end
			end
			// Read data held until rReady
			if (rFire) begin
				axiRsp.rValid = 1'b0;
			end
			if (rPending) begin
				if (rWait == 0) begin
					axiRsp.rValid = 1'b1;
					axiRsp.rData = mem[memIndex(rdAddr)];
					axiRsp.rResp = 2'b00;
					rPending = 1'b0;
				end else begin
					rWait--;
				end
			end
			// Write address
			if (awFire) begin
				axiRsp.awReady = 1'b0;
				haveAw = 1'b1;
			end else if (axiReq.awValid && !axiRsp.awReady) begin
				if (awWait < 0) begin
					awWait = pickDelay();
				end
				if (awWait == 0) begin
					axiRsp.awReady = 1'b1;
					awWait = -1;
				end else begin
					awWait--;
				end
			end
			// Write data
			if (wFire) begin
				axiRsp.wReady = 1'b0;
				haveW = 1'b1;
			end else if (axiReq.wValid && !axiRsp.wReady) begin
				if (wWait < 0) begin
					wWait = pickDelay();
				end
				if (wWait == 0) begin
					axiRsp.wReady = 1'b1;
					wWait = -1;
				end else begin
					wWait--;
				end
			end
			// Both halves in, commit and log
			if (haveAw && haveW) begin
				mem[memIndex(wrAddr)] = wrData;
				storeAddrQ.push_back(wrAddr);
				storeDataQ.push_back(wrData);
				haveAw = 1'b0;
				haveW = 1'b0;
				bPending = 1'b1;
				bWait = pickDelay();
			end
			// Write response
			if (bFire) begin
				axiRsp.bValid = 1'b0;
			end
			if (bPending) begin
				if (bWait == 0) begin
					axiRsp.bValid = 1'b1;
					axiRsp.bResp = 2'b00;
					bPending = 1'b0;
				end else begin
					bWait--;
				end
			end
		end
	end

endmodule

// ==== dv/multicycleCore_asserts.sv ====
`timescale 1ns/1ps

module multicycleCore_asserts (
	input logic cclk,
	input logic rstb,
	input mipsPkg::axiReqT axiReq,
	input mipsPkg::axiRspT axiRsp
);

	// Read address held until accepted
	property holdRead;
		@(posedge cclk) disable iff (!rstb)
		(axiReq.arValid && !axiRsp.arReady) |=> (axiReq.arValid && $stable(axiReq.arAddr));
	endproperty

	// Write address held until accepted
	property holdWriteAddr;
		@(posedge cclk) disable iff (!rstb)
		(axiReq.awValid && !axiRsp.awReady) |=> (axiReq.awValid && $stable(axiReq.awAddr));
	endproperty

	// Write data held until accepted
	property holdWriteData;
		@(posedge cclk) disable iff (!rstb)
		(axiReq.wValid && !axiRsp.wReady) |=> (axiReq.wValid && $stable(axiReq.wData));
	endproperty

	// Quiet bus in reset and one cycle after
	property quietReset;
		@(posedge cclk)
		!rstb |=> !(axiReq.arValid || axiReq.awValid || axiReq.wValid
			|| axiReq.rReady || axiReq.bReady);
	endproperty

	// Word stores only
	property fullStrobe;
		@(posedge cclk) disable iff (!rstb)
		axiReq.wValid |-> (axiReq.wStrb == '1);
	endproperty

	assert property (holdRead) else $error("arValid or arAddr changed before arReady");
	assert property (holdWriteAddr) else $error("awValid or awAddr changed before awReady");
	assert property (holdWriteData) else $error("wValid or wData changed before wReady");
	assert property (quietReset) else $error("AXI valid or ready high around reset");
	assert property (fullStrobe) else $error("wStrb not all ones on a write");

endmodule

bind multicycleCore multicycleCore_asserts assertsI (
	.cclk(cclk),
	.rstb(rstb),
	.axiReq(axiReq),
	.axiRsp(axiRsp)
);

// ==== dv/multicycleCoreTb.sv ====
`timescale 1ns/1ps

module multicycleCoreTb;

	localparam int cycleLimit = 4000;
	localparam int settleCycles = 40;
	localparam logic [31:0] dataBase = 32'h200;

	logic cclk;
	logic rstb;
	logic slowMode;
	mipsPkg::axiReqT axiReq;
	mipsPkg::axiRspT axiRsp;

	logic [31:0] prog [$];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	// Store log of the fast arithmetic run
	logic [31:0] fastAddr [$];
	logic [31:0] fastData [$];
	string testName;
	int cycleCount;
	int errorCount;
	int testErrors;
	int testCount;
	int checkCount;

	multicycleCore dut_i (
		.cclk(cclk),
		.rstb(rstb),
		.axiReq(axiReq),
		.axiRsp(axiRsp)
	);

	axiLiteMemoryModel memModelI (
		.cclk(cclk),
		.rstb(rstb),
		.slowMode(slowMode),
		.axiReq(axiReq),
		.axiRsp(axiRsp)
	);

	initial begin
		cclk = 1'b0;
	end
	always #2 cclk = ~cclk;

	// Per-test watchdog
	always @(posedge cclk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: test %s did not finish its stores in %0d cycles",
				testName, cycleLimit);
			$display("Finished with errors");
			$finish;
		end
	end

	// Instruction encoders
	function automatic logic [31:0] rOp(int rd, int rs, int rt, mipsPkg::functT f);
		return {mipsPkg::rType, 5'(rs), 5'(rt), 5'(rd), 5'd0, f};
	endfunction

	function automatic logic [31:0] iOp(mipsPkg::opcodeT op, int rt, int rs, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] jOp(logic [31:0] addr);
		return {mipsPkg::jType, addr[27:2]};
	endfunction

	function automatic logic [31:0] sext(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic logic [31:0] zext(logic [15:0] imm);
		return {16'h0000, imm};
	endfunction

	task automatic emit(logic [31:0] word);
		prog.push_back(word);
	endtask

	// Final jump to itself
	task automatic emitHalt();
		emit(jOp(32'(prog.size() * 4)));
	endtask

	task automatic expectStore(logic [31:0] addr, logic [31:0] data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic checkValue(string what, logic [31:0] expected, logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			$display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	// Core held in reset while memory is reloaded
	task automatic beginTest(string name, logic slow);
		@(negedge cclk);
		rstb = 1'b0;
		slowMode = slow;
		@(negedge cclk);
		testName = name;
		testErrors = 0;
		cycleCount = 0;
		prog.delete();
		expAddr.delete();
		expData.delete();
		memModelI.clearMemory();
		memModelI.clearLog();
	endtask

	task automatic runProgram();
		for (int i = 0; i < prog.size(); i++) begin
			memModelI.writeWord(32'(i * 4), prog[i]);
		end
		repeat (3) @(negedge cclk);
		rstb = 1'b1;
		while (memModelI.storeCount() < expAddr.size()) begin
			@(negedge cclk);
		end
		// Extra time so an unexpected store shows up
		repeat (settleCycles) @(negedge cclk);
	endtask

	task automatic checkStores();
		int n;
		checkValue("store count", 32'(expAddr.size()), 32'(memModelI.storeCount()));
		n = (expAddr.size() < memModelI.storeCount()) ? expAddr.size() : memModelI.storeCount();
		for (int i = 0; i < n; i++) begin
			checkValue($sformatf("store %0d address", i), expAddr[i], memModelI.storeAddrAt(i));
			checkValue($sformatf("store %0d data", i), expData[i], memModelI.storeDataAt(i));
		end
		testCount++;
		$display("Test %s finished with %0d error(s)", testName, testErrors);
	endtask

	// R-type ops on addi constants, rerun under back-pressure
	task automatic arithTest(logic slow);
		logic [15:0] immA;
		logic [15:0] immB;
		logic [31:0] a;
		logic [31:0] b;
		immA = 16'h1234;
		immB = 16'hf0f5;
		a = sext(immA);
		b = sext(immB);
		beginTest(slow ? "backPressure" : "arithmetic", slow);
		emit(iOp(mipsPkg::addi, 1, 0, immA));
		emit(iOp(mipsPkg::addi, 2, 0, immB));
		emit(rOp(3, 1, 2, mipsPkg::functAdd));
		emit(rOp(4, 1, 2, mipsPkg::functSub));
		emit(rOp(5, 1, 2, mipsPkg::functAnd));
		emit(rOp(6, 1, 2, mipsPkg::functOr));
		emit(rOp(7, 2, 1, mipsPkg::functSlt));
		emit(rOp(8, 1, 2, mipsPkg::functSlt));
		for (int r = 3; r <= 8; r++) begin
			emit(iOp(mipsPkg::sw, r, 0, 16'(dataBase + (r - 3) * 4)));
		end
		emitHalt();
		expectStore(dataBase, a + b);
		expectStore(dataBase + 4, a - b);
		expectStore(dataBase + 8, a & b);
		expectStore(dataBase + 12, a | b);
		expectStore(dataBase + 16, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		expectStore(dataBase + 20, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		runProgram();
		if (!slow) begin
			fastAddr.delete();
			fastData.delete();
			for (int i = 0; i < memModelI.storeCount(); i++) begin
				fastAddr.push_back(memModelI.storeAddrAt(i));
				fastData.push_back(memModelI.storeDataAt(i));
			end
		end else begin
			// Same log as the fast run
			for (int i = 0; i < fastAddr.size(); i++) begin
				checkValue($sformatf("fast log %0d address", i), fastAddr[i],
					memModelI.storeAddrAt(i));
				checkValue($sformatf("fast log %0d data", i), fastData[i],
					memModelI.storeDataAt(i));
			end
		end
		checkStores();
	endtask

	// Sign extension for addi, zero extension for andi/ori
	task automatic immTest();
		logic [31:0] a;
		a = sext(16'h8001);
		beginTest("immediate", 1'b0);
		emit(iOp(mipsPkg::addi, 1, 0, 16'h8001));
		emit(iOp(mipsPkg::andi, 2, 1, 16'h8f0f));
		emit(iOp(mipsPkg::ori, 3, 0, 16'hf00f));
		// Source has clear upper half, so extension shows in the result
		emit(iOp(mipsPkg::ori, 4, 2, 16'h8000));
		emit(iOp(mipsPkg::addi, 5, 1, 16'hfffe));
		for (int r = 1; r <= 5; r++) begin
			emit(iOp(mipsPkg::sw, r, 0, 16'(dataBase + (r - 1) * 4)));
		end
		emitHalt();
		expectStore(dataBase, a);
		expectStore(dataBase + 4, a & zext(16'h8f0f));
		expectStore(dataBase + 8, zext(16'hf00f));
		expectStore(dataBase + 12, (a & zext(16'h8f0f)) | zext(16'h8000));
		expectStore(dataBase + 16, a + sext(16'hfffe));
		runProgram();
		checkStores();
	endtask

	// Preloaded word, incremented, stored twice
	task automatic loadStoreTest();
		logic [31:0] word;
		word = 32'h7fff_fffe;
		beginTest("loadStore", 1'b0);
		memModelI.writeWord(32'h300, word);
		emit(iOp(mipsPkg::lw, 1, 0, 16'h0300));
		emit(iOp(mipsPkg::addi, 1, 1, 16'h0003));
		emit(iOp(mipsPkg::sw, 1, 0, 16'h0304));
		emit(iOp(mipsPkg::addi, 2, 0, 16'h0100));
		emit(iOp(mipsPkg::sw, 1, 2, 16'h0208));
		emitHalt();
		expectStore(32'h304, word + sext(16'h0003));
		expectStore(32'h100 + sext(16'h0208), word + sext(16'h0003));
		runProgram();
		checkStores();
	endtask

	// r0 ignores every write
	task automatic zeroRegTest();
		beginTest("registerZero", 1'b0);
		emit(iOp(mipsPkg::addi, 0, 0, 16'h0055));
		emit(iOp(mipsPkg::ori, 0, 0, 16'h0f0f));
		emit(iOp(mipsPkg::addi, 1, 0, 16'h0021));
		emit(rOp(0, 1, 1, mipsPkg::functAdd));
		emit(iOp(mipsPkg::sw, 0, 0, 16'(dataBase)));
		emit(iOp(mipsPkg::sw, 1, 0, 16'(dataBase + 4)));
		emitHalt();
		expectStore(dataBase, 32'h0);
		expectStore(dataBase + 4, 32'h21);
		runProgram();
		checkStores();
	endtask

	// Taken and not-taken beq, then j over a block
	task automatic controlFlowTest();
		beginTest("controlFlow", 1'b0);
		emit(iOp(mipsPkg::addi, 1, 0, 16'd7));
		emit(iOp(mipsPkg::addi, 2, 0, 16'd7));
		emit(iOp(mipsPkg::addi, 3, 0, 16'd9));
		// Taken, skips the store at 16
		emit(iOp(mipsPkg::beq, 2, 1, 16'd1));
		emit(iOp(mipsPkg::sw, 1, 0, 16'(dataBase)));
		// Not taken
		emit(iOp(mipsPkg::beq, 3, 1, 16'd1));
		emit(iOp(mipsPkg::sw, 3, 0, 16'(dataBase + 4)));
		emit(jOp(32'd40));
		emit(iOp(mipsPkg::sw, 1, 0, 16'(dataBase + 8)));
		emit(iOp(mipsPkg::sw, 1, 0, 16'(dataBase + 12)));
		emit(iOp(mipsPkg::sw, 2, 0, 16'(dataBase + 16)));
		emitHalt();
		expectStore(dataBase + 4, 32'd9);
		expectStore(dataBase + 16, 32'd7);
		runProgram();
		checkStores();
	endtask

	initial begin
		rstb = 1'b0;
		slowMode = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		testErrors = 0;
		testCount = 0;
		checkCount = 0;
		testName = "startup";
		arithTest(1'b0);
		immTest();
		loadStoreTest();
		zeroRegTest();
		controlFlowTest();
		arithTest(1'b1);
		$display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== multicycleCore.f ====
hdl/mipsPkg.sv
hdl/controlUnit.sv
hdl/aluDecoder.sv
hdl/registerFile.sv
hdl/datapath.sv
hdl/multicycleCore.sv
dv/axiLiteMemoryModel.sv
dv/multicycleCore_asserts.sv
dv/multicycleCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= multicycleCoreTb
FILELIST ?= multicycleCore.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
